// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbWriteBack
FLIST     ?= writeBack.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TEST OK

SRCS := writeBack_consts.svh wbPkg.sv exeLaneWb.sv lsuLaneWb.sv writeBack.sv tbWriteBack.sv
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: exeLaneWb.sv
// Execution-lane writeback register; instantiated by the writeback top once per ALU or control lane.
module exeLaneWb
        import wbPkg::*;
(
        input  logic       clk,
        input  logic       reset,

        input  logic       valid_i,
        input  exePacket_t packet_i,
        input  squash_t    squash_i,

        output logic       wbValid_o,
        output wbCtrl_t    wbCtrl_o,
        output logic       bypassValid_o,
        output bypass_t    bypass_o,

        output logic       heldValid_o,
        output exePacket_t heldPacket_o
);

        logic       heldValid;
        exePacket_t heldPacket;
        logic       squashHit;

        // The valid bit follows the strobe every cycle.
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        heldValid <= 1'b0;
                end
                else
                begin
                        heldValid <= valid_i;
                end
        end

        // The payload only loads with a valid packet and otherwise keeps the last one.
        always_ff @(posedge clk)
        begin
                if (valid_i)
                begin
                        heldPacket <= packet_i;
                end
        end

        // A mispredicted branch kills every younger instruction that depends on it.
        assign squashHit = squash_i.valid && heldPacket.mask[squash_i.checkpointId];

        always_comb
        begin
                wbValid_o      = heldValid && !squashHit;
                wbCtrl_o.alId  = heldPacket.alId;
                wbCtrl_o.flags = heldPacket.flags.wb;
        end

        // Bypass goes out even for a squashed packet.
        always_comb
        begin
                bypassValid_o = heldValid && heldPacket.flags.hasDest;
                bypass_o.tag  = heldPacket.dest;
                bypass_o.data = heldPacket.result;
        end

        assign heldValid_o  = heldValid;
        assign heldPacket_o = heldPacket;

        // A writeback needs a packet captured on the edge before.
        wbNeedsCapture: assert property (@(posedge clk) disable iff (reset)
                $rose(wbValid_o) |-> $past(valid_i))
                else $error("exeLaneWb: writeback raised without a captured packet.");

endmodule

// File: lsuLaneWb.sv
// Load/store-lane writeback register with issue-queue release; instantiated once by the writeback top.
module lsuLaneWb
        import wbPkg::*;
(
        input  logic       clk,
        input  logic       reset,

        input  logic       valid_i,
        input  lsuPacket_t packet_i,
        input  squash_t    squash_i,

        output logic       wbValid_o,
        output wbCtrl_t    wbCtrl_o,
        output logic       bypassValid_o,
        output bypass_t    bypass_o,

        output logic       iqFreeValid_o,
        output iqIndex_t   iqEntry_o
);

        logic       heldValid;
        lsuPacket_t heldPacket;
        logic       squashHit;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        heldValid <= 1'b0;
                end
                else
                begin
                        heldValid <= valid_i;
                end
        end

        always_ff @(posedge clk)
        begin
                if (valid_i)
                begin
                        heldPacket <= packet_i;
                end
        end

        assign squashHit = squash_i.valid && heldPacket.mask[squash_i.checkpointId];

        always_comb
        begin
                wbValid_o      = heldValid && !squashHit;
                wbCtrl_o.alId  = heldPacket.alId;
                wbCtrl_o.flags = heldPacket.flags.wb;
                bypassValid_o  = heldValid && heldPacket.flags.hasDest;
                bypass_o.tag   = heldPacket.dest;
                bypass_o.data  = heldPacket.result;
        end

        // The address-generation entry is freed whether or not the access is squashed.
        assign iqFreeValid_o = heldValid;
        assign iqEntry_o     = heldPacket.iqEntry;

        // A squash only takes back the writeback, never the issue-queue release.
        squashKeepsFree: assert property (@(posedge clk) disable iff (reset)
                (squashHit && $past(valid_i && !reset)) |-> (iqFreeValid_o
                        && iqEntry_o == $past(packet_i.iqEntry)))
                else $error("lsuLaneWb: squash lowered the issue-queue release.");

endmodule

// File: tbWriteBack.sv
// Self-checking testbench for the writeback stage; drives LFSR packets and compares every output.
`include "writeBack_consts.svh"

module tbWriteBack
        import wbPkg::*;
;

        localparam int RESET_CYCLES  = 4;
        localparam int RUN_CYCLES    = 400;
        localparam int RESET_TIMEOUT = 20;
        localparam int RUN_TIMEOUT   = 1000;

        // Expected view of every DUT output for one cycle.
        typedef struct packed {
                logic [3:0]          wbValid;
                wbCtrl_t [3:0]       wbCtrl;
                logic [3:0]          bypassValid;
                bypass_t [3:0]       bypass;
                logic                iqFreeValid;
                iqIndex_t            iqEntry;
                logic                resolveValid;
                branchResult_t       branch;
        } expect_t;

        logic          clk = 1'b0;
        logic          reset = 1'b1;
        logic          exeValid0 = 1'b0;
        logic          exeValid1 = 1'b0;
        logic          exeValid2 = 1'b0;
        logic          lsuValid = 1'b0;
        exePacket_t    exePacket0 = '0;
        exePacket_t    exePacket1 = '0;
        exePacket_t    exePacket2 = '0;
        lsuPacket_t    lsuPacket = '0;

        logic          wbValid0, wbValid1, wbValid2, wbValid3;
        wbCtrl_t       wbCtrl0, wbCtrl1, wbCtrl2, wbCtrl3;
        logic          bypassValid0, bypassValid1, bypassValid2, bypassValid3;
        bypass_t       bypass0, bypass1, bypass2, bypass3;
        logic          iqFreeValid;
        iqIndex_t      iqEntry;
        logic          resolveValid;
        branchResult_t branch;

        // Inputs as they stood at the last rising edge.
        logic          prevReset = 1'b1;
        logic [3:0]    prevValid = 4'b0000;
        exePacket_t    prevExe0 = '0;
        exePacket_t    prevExe1 = '0;
        exePacket_t    prevExe2 = '0;
        lsuPacket_t    prevLsu = '0;

        logic [31:0]   lfsrState = 32'd74528;
        int            stimCycle = 0;
        int            checkedCycles = 0;
        int            squashedWb = 0; // Writebacks killed by a mispredict.
        int            survivedWb = 0;

        writeBack i_writeBack (
                .clk            (clk),
                .reset          (reset),
                .exeValid0_i    (exeValid0),
                .exePacket0_i   (exePacket0),
                .exeValid1_i    (exeValid1),
                .exePacket1_i   (exePacket1),
                .exeValid2_i    (exeValid2),
                .exePacket2_i   (exePacket2),
                .lsuValid_i     (lsuValid),
                .lsuPacket_i    (lsuPacket),
                .wbValid0_o     (wbValid0),
                .wbCtrl0_o      (wbCtrl0),
                .wbValid1_o     (wbValid1),
                .wbCtrl1_o      (wbCtrl1),
                .wbValid2_o     (wbValid2),
                .wbCtrl2_o      (wbCtrl2),
                .wbValid3_o     (wbValid3),
                .wbCtrl3_o      (wbCtrl3),
                .bypassValid0_o (bypassValid0),
                .bypass0_o      (bypass0),
                .bypassValid1_o (bypassValid1),
                .bypass1_o      (bypass1),
                .bypassValid2_o (bypassValid2),
                .bypass2_o      (bypass2),
                .bypassValid3_o (bypassValid3),
                .bypass3_o      (bypass3),
                .iqFreeValid_o  (iqFreeValid),
                .iqEntry_o      (iqEntry),
                .resolveValid_o (resolveValid),
                .branch_o       (branch)
        );

        initial
        begin
                forever #20 clk = ~clk;
        end

        task automatic abortRun();
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped at the first failure.");
        endtask

        task automatic checkBit(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                        abortRun();
                end
        endtask

        task automatic checkWbCtrl(input string name, input wbCtrl_t got, input wbCtrl_t exp);
                if (got !== exp)
                begin
                        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                        abortRun();
                end
        endtask

        task automatic checkBypass(input string name, input bypass_t got, input bypass_t exp);
                if (got !== exp)
                begin
                        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                        abortRun();
                end
        endtask

        task automatic checkBranch(input string name, input branchResult_t got,
                                   input branchResult_t exp);
                if (got !== exp)
                begin
                        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                        abortRun();
                end
        endtask

        task automatic checkIqEntry(input string name, input iqIndex_t got, input iqIndex_t exp);
                if (got !== exp)
                begin
                        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                        abortRun();
                end
        endtask

        // Galois form of x^32 + x^22 + x^2 + x + 1.
        function automatic logic [31:0] lfsrNext(input logic [31:0] state);
                logic [31:0] next;
                next = state >> 1;
                if (state[0])
                begin
                        next = next ^ 32'h80200003;
                end
                return next;
        endfunction

        function automatic logic [31:0] takeBits(input int count);
                logic [31:0] bits;
                bits = '0;
                for (int i = 0; i < count; i++)
                begin
                        bits = {bits[30:0], lfsrState[0]};
                        lfsrState = lfsrNext(lfsrState);
                end
                return bits;
        endfunction

        function automatic exePacket_t randomExePacket();
                exePacket_t p;
                p.mask                = checkpointMask_t'(takeBits(`CHECKPOINTS));
                p.flags.isConditional = 1'(takeBits(1));
                p.flags.hasDest       = 1'(takeBits(1));
                p.flags.wb.mispredict = (takeBits(2) == 32'd3); // Roughly one in four.
                p.flags.wb.exception  = 1'(takeBits(1));
                p.flags.wb.executed   = 1'(takeBits(1));
                p.dest                = physReg_t'(takeBits(`SIZE_PHYSICAL_LOG));
                p.alId                = alIndex_t'(takeBits(`SIZE_ACTIVELIST_LOG));
                p.result              = data_t'(takeBits(`SIZE_DATA));
                p.checkpointId        = checkpointId_t'(takeBits(`CHECKPOINTS_LOG));
                p.ctiIndex            = ctiIndex_t'(takeBits(`SIZE_CTI_LOG));
                p.target              = pc_t'(takeBits(`SIZE_PC));
                p.direction           = 1'(takeBits(1));
                return p;
        endfunction

        function automatic lsuPacket_t randomLsuPacket();
                lsuPacket_t p;
                p.mask    = checkpointMask_t'(takeBits(`CHECKPOINTS));
                p.flags   = exeFlags_t'(takeBits(5));
                p.result  = data_t'(takeBits(`SIZE_DATA));
                p.dest    = physReg_t'(takeBits(`SIZE_PHYSICAL_LOG));
                p.alId    = alIndex_t'(takeBits(`SIZE_ACTIVELIST_LOG));
                p.iqEntry = iqIndex_t'(takeBits(`SIZE_ISSUEQ_LOG));
                return p;
        endfunction

        // Outputs one cycle after the given inputs, from the stage's rules.
        function automatic expect_t referenceOutputs(input logic rst, input logic [3:0] strobes,
                input exePacket_t exe0, input exePacket_t exe1, input exePacket_t exe2,
                input lsuPacket_t lsu);
                expect_t       e;
                logic [3:0]    held;
                logic          killValid;
                checkpointId_t killId;
                exePacket_t    exe [3];
                e = '0;
                exe[0] = exe0;
                exe[1] = exe1;
                exe[2] = exe2;
                held = rst ? 4'b0000 : strobes;
                killValid = held[2] && exe2.flags.wb.mispredict;
                killId = exe2.checkpointId;
                for (int i = 0; i < 3; i++)
                begin
                        e.wbValid[i]       = held[i] && !(killValid && exe[i].mask[killId]);
                        e.wbCtrl[i].alId   = exe[i].alId;
                        e.wbCtrl[i].flags  = exe[i].flags.wb;
                        e.bypassValid[i]   = held[i] && exe[i].flags.hasDest;
                        e.bypass[i].tag    = exe[i].dest;
                        e.bypass[i].data   = exe[i].result;
                end
                e.wbValid[3]            = held[3] && !(killValid && lsu.mask[killId]);
                e.wbCtrl[3].alId        = lsu.alId;
                e.wbCtrl[3].flags       = lsu.flags.wb;
                e.bypassValid[3]        = held[3] && lsu.flags.hasDest;
                e.bypass[3].tag         = lsu.dest;
                e.bypass[3].data        = lsu.result;
                e.iqFreeValid           = held[3];
                e.iqEntry               = lsu.iqEntry;
                e.resolveValid          = held[2];
                e.branch.conditional    = exe2.flags.isConditional;
                e.branch.mispredict     = exe2.flags.wb.mispredict;
                e.branch.checkpointId   = exe2.checkpointId;
                e.branch.target         = exe2.target;
                e.branch.direction      = exe2.direction;
                e.branch.ctiIndex       = exe2.ctiIndex;
                return e;
        endfunction

        task automatic tallySquashCases();
                checkpointMask_t masks [4];
                logic            killValid;
                masks[0] = prevExe0.mask;
                masks[1] = prevExe1.mask;
                masks[2] = prevExe2.mask;
                masks[3] = prevLsu.mask;
                killValid = !prevReset && prevValid[2] && prevExe2.flags.wb.mispredict;
                for (int i = 0; i < 4; i++)
                begin
                        if (killValid && prevValid[i])
                        begin
                                if (masks[i][prevExe2.checkpointId])
                                begin
                                        squashedWb++;
                                end
                                else
                                begin
                                        survivedWb++;
                                end
                        end
                end
        endtask

        always @(posedge clk)
        begin
                logic [3:0] strobes;
                exePacket_t p0, p1, p2;
                lsuPacket_t pl;
                prevReset = reset; // The DUT samples these old values at this edge.
                prevValid = {lsuValid, exeValid2, exeValid1, exeValid0};
                prevExe0  = exePacket0;
                prevExe1  = exePacket1;
                prevExe2  = exePacket2;
                prevLsu   = lsuPacket;
                stimCycle++;
                if (stimCycle == RESET_CYCLES)
                begin
                        reset <= 1'b0;
                end
                strobes = 4'(takeBits(4) | takeBits(4));
                p0 = randomExePacket();
                p1 = randomExePacket();
                p2 = randomExePacket();
                pl = randomLsuPacket();
                // Every eighth cycle a mispredict hits lanes 0 and 3 and spares lane 1.
                if (stimCycle % 8 == 0)
                begin
                        strobes = 4'b1111;
                        p2.flags.wb.mispredict = 1'b1;
                        p0.mask[p2.checkpointId] = 1'b1;
                        p1.mask[p2.checkpointId] = 1'b0;
                        pl.mask[p2.checkpointId] = 1'b1;
                end
                exeValid0  <= strobes[0];
                exeValid1  <= strobes[1];
                exeValid2  <= strobes[2];
                lsuValid   <= strobes[3];
                exePacket0 <= p0;
                exePacket1 <= p1;
                exePacket2 <= p2;
                lsuPacket  <= pl;
        end

        always @(negedge clk)
        begin : compareOutputs
                expect_t    exp;
                logic [3:0] gotWbValid;
                logic [3:0] gotBypassValid;
                wbCtrl_t    gotWbCtrl [4];
                bypass_t    gotBypass [4];
                exp = referenceOutputs(prevReset, prevValid, prevExe0, prevExe1, prevExe2, prevLsu);
                gotWbValid     = {wbValid3, wbValid2, wbValid1, wbValid0};
                gotBypassValid = {bypassValid3, bypassValid2, bypassValid1, bypassValid0};
                gotWbCtrl[0] = wbCtrl0;
                gotWbCtrl[1] = wbCtrl1;
                gotWbCtrl[2] = wbCtrl2;
                gotWbCtrl[3] = wbCtrl3;
                gotBypass[0] = bypass0;
                gotBypass[1] = bypass1;
                gotBypass[2] = bypass2;
                gotBypass[3] = bypass3;
                for (int i = 0; i < 4; i++)
                begin
                        checkBit($sformatf("wbValid%0d_o", i), gotWbValid[i], exp.wbValid[i]);
                        if (exp.wbValid[i])
                        begin
                                checkWbCtrl($sformatf("wbCtrl%0d_o", i), gotWbCtrl[i],
                                            exp.wbCtrl[i]);
                        end
                        checkBit($sformatf("bypassValid%0d_o", i), gotBypassValid[i],
                                 exp.bypassValid[i]);
                        if (exp.bypassValid[i])
                        begin
                                checkBypass($sformatf("bypass%0d_o", i), gotBypass[i],
                                            exp.bypass[i]);
                        end
                end
                checkBit("iqFreeValid_o", iqFreeValid, exp.iqFreeValid);
                if (exp.iqFreeValid)
                begin
                        checkIqEntry("iqEntry_o", iqEntry, exp.iqEntry);
                end
                checkBit("resolveValid_o", resolveValid, exp.resolveValid);
                if (exp.resolveValid)
                begin
                        checkBranch("branch_o", branch, exp.branch);
                end
                tallySquashCases();
                checkedCycles++;
        end

        initial
        begin
                int waited;
                waited = 0;
                while (reset !== 1'b0)
                begin
                        @(posedge clk);
                        waited++;
                        if (waited > RESET_TIMEOUT)
                        begin
                                $display("Reset was never released.");
                                abortRun();
                        end
                end
                waited = 0;
                while (checkedCycles < RUN_CYCLES)
                begin
                        @(posedge clk);
                        waited++;
                        if (waited > RUN_TIMEOUT)
                        begin
                                $display("The compare process stopped counting cycles.");
                                abortRun();
                        end
                end
                if (squashedWb == 0 || survivedWb == 0)
                begin
                        $display("A squash never both killed and spared a lane.");
                        abortRun();
                end
                else
                begin
                        $display("TEST OK");
                        $finish;
                end
        end

endmodule

// File: wbPkg.sv
// Shared types for the writeback stage; imported by every RTL module and the testbench.
`include "writeBack_consts.svh"

package wbPkg;

        // One bit per unresolved branch the instruction depends on.
        typedef logic [`CHECKPOINTS-1:0]         checkpointMask_t;
        typedef logic [`CHECKPOINTS_LOG-1:0]     checkpointId_t;
        typedef logic [`SIZE_PHYSICAL_LOG-1:0]   physReg_t;
        typedef logic [`SIZE_ACTIVELIST_LOG-1:0] alIndex_t;
        typedef logic [`SIZE_DATA-1:0]           data_t;
        typedef logic [`SIZE_ISSUEQ_LOG-1:0]     iqIndex_t;
        typedef logic [`SIZE_CTI_LOG-1:0]        ctiIndex_t;
        typedef logic [`SIZE_PC-1:0]             pc_t;

        // Flags that go on to the active list.
        typedef struct packed {
                logic mispredict;
                logic exception;
                logic executed;
        } wbFlags_t;

        typedef struct packed {
                logic     isConditional;
                logic     hasDest;
                wbFlags_t wb;
        } exeFlags_t;

        // Packet from a simple ALU or control execution lane.
        typedef struct packed {
                checkpointMask_t mask;
                exeFlags_t       flags;
                physReg_t        dest;
                alIndex_t        alId;
                data_t           result;
                checkpointId_t   checkpointId; // Checkpoint taken by a branch.
                ctiIndex_t       ctiIndex;
                pc_t             target;
                logic            direction;
        } exePacket_t;

        // Packet from the load/store lane.
        typedef struct packed {
                checkpointMask_t mask;
                exeFlags_t       flags;
                data_t           result;
                physReg_t        dest;
                alIndex_t        alId;
                iqIndex_t        iqEntry; // Address-generation issue-queue entry.
        } lsuPacket_t;

        // Writeback record for the active list.
        typedef struct packed {
                alIndex_t alId;
                wbFlags_t flags;
        } wbCtrl_t;

        typedef struct packed {
                physReg_t tag;
                data_t    data;
        } bypass_t;

        // Resolution of the branch held in the control lane.
        typedef struct packed {
                logic          conditional;
                logic          mispredict;
                checkpointId_t checkpointId;
                pc_t           target;
                logic          direction;
                ctiIndex_t     ctiIndex;
        } branchResult_t;

        typedef struct packed {
                logic          valid;
                checkpointId_t checkpointId;
        } squash_t;

endpackage

// File: writeBack.f
+incdir+.
wbPkg.sv
exeLaneWb.sv
lsuLaneWb.sv
writeBack.sv
tbWriteBack.sv

// File: writeBack.sv
// Writeback stage top level; drives active-list, bypass and branch outputs from four lanes.
module writeBack
        import wbPkg::*;
(
        input  logic          clk,
        input  logic          reset,

        input  logic          exeValid0_i,
        input  exePacket_t    exePacket0_i,
        input  logic          exeValid1_i,
        input  exePacket_t    exePacket1_i,
        input  logic          exeValid2_i,
        input  exePacket_t    exePacket2_i,
        input  logic          lsuValid_i,
        input  lsuPacket_t    lsuPacket_i,

        output logic          wbValid0_o,
        output wbCtrl_t       wbCtrl0_o,
        output logic          wbValid1_o,
        output wbCtrl_t       wbCtrl1_o,
        output logic          wbValid2_o,
        output wbCtrl_t       wbCtrl2_o,
        output logic          wbValid3_o,
        output wbCtrl_t       wbCtrl3_o,

        output logic          bypassValid0_o,
        output bypass_t       bypass0_o,
        output logic          bypassValid1_o,
        output bypass_t       bypass1_o,
        output logic          bypassValid2_o,
        output bypass_t       bypass2_o,
        output logic          bypassValid3_o,
        output bypass_t       bypass3_o,

        output logic          iqFreeValid_o,
        output iqIndex_t      iqEntry_o,

        output logic          resolveValid_o,
        output branchResult_t branch_o
);

        logic       ctrlHeldValid;
        exePacket_t ctrlHeld;
        squash_t    squash;

        exeLaneWb lane0 (
                .clk           (clk),
                .reset         (reset),
                .valid_i       (exeValid0_i),
                .packet_i      (exePacket0_i),
                .squash_i      (squash),
                .wbValid_o     (wbValid0_o),
                .wbCtrl_o      (wbCtrl0_o),
                .bypassValid_o (bypassValid0_o),
                .bypass_o      (bypass0_o),
                .heldValid_o   (),
                .heldPacket_o  ()
        );

        exeLaneWb lane1 (
                .clk           (clk),
                .reset         (reset),
                .valid_i       (exeValid1_i),
                .packet_i      (exePacket1_i),
                .squash_i      (squash),
                .wbValid_o     (wbValid1_o),
                .wbCtrl_o      (wbCtrl1_o),
                .bypassValid_o (bypassValid1_o),
                .bypass_o      (bypass1_o),
                .heldValid_o   (),
                .heldPacket_o  ()
        );

        // Lane 2 carries branches, so its held packet feeds the resolution below.
        exeLaneWb ctrlLane (
                .clk           (clk),
                .reset         (reset),
                .valid_i       (exeValid2_i),
                .packet_i      (exePacket2_i),
                .squash_i      (squash),
                .wbValid_o     (wbValid2_o),
                .wbCtrl_o      (wbCtrl2_o),
                .bypassValid_o (bypassValid2_o),
                .bypass_o      (bypass2_o),
                .heldValid_o   (ctrlHeldValid),
                .heldPacket_o  (ctrlHeld)
        );

        lsuLaneWb lsuLane (
                .clk           (clk),
                .reset         (reset),
                .valid_i       (lsuValid_i),
                .packet_i      (lsuPacket_i),
                .squash_i      (squash),
                .wbValid_o     (wbValid3_o),
                .wbCtrl_o      (wbCtrl3_o),
                .bypassValid_o (bypassValid3_o),
                .bypass_o      (bypass3_o),
                .iqFreeValid_o (iqFreeValid_o),
                .iqEntry_o     (iqEntry_o)
        );

        // Branch resolution comes straight from the held control packet.
        always_comb
        begin
                resolveValid_o        = ctrlHeldValid;
                branch_o.conditional  = ctrlHeld.flags.isConditional;
                branch_o.mispredict   = ctrlHeld.flags.wb.mispredict;
                branch_o.checkpointId = ctrlHeld.checkpointId;
                branch_o.target       = ctrlHeld.target;
                branch_o.direction    = ctrlHeld.direction;
                branch_o.ctiIndex     = ctrlHeld.ctiIndex;
        end

        // The squash reaches all four lanes in the same cycle, the control lane included.
        always_comb
        begin
                squash.valid        = ctrlHeldValid && ctrlHeld.flags.wb.mispredict;
                squash.checkpointId = ctrlHeld.checkpointId;
        end

        // Lanes are squashed only by a mispredicted branch taken in on the edge before.
        squashFromResolve: assert property (@(posedge clk) disable iff (reset)
                squash.valid |-> (resolveValid_o
                        && $past(exeValid2_i && exePacket2_i.flags.wb.mispredict)
                        && squash.checkpointId == $past(exePacket2_i.checkpointId)))
                else $error("writeBack: squash without a matching branch resolution.");

endmodule

// File: writeBack_consts.svh
// Width and count macros for the writeback stage, included by the shared package and the testbench.
`ifndef WRITEBACK_CONSTS_SVH
`define WRITEBACK_CONSTS_SVH

// Branch checkpoints that can be in flight at once.
`define CHECKPOINTS 4

// Width of a checkpoint id.
`define CHECKPOINTS_LOG 2

// Width of a physical register tag.
`define SIZE_PHYSICAL_LOG 7

`define SIZE_ACTIVELIST_LOG 7 // Active-list index width.

// Width of an execution result.
`define SIZE_DATA 32

// Width of an issue-queue entry index.
`define SIZE_ISSUEQ_LOG 5

`define SIZE_CTI_LOG 4 // Control-transfer queue index width.

// Width of an instruction address.
`define SIZE_PC 32

`endif
